//--- compile.f
hw/sys_ctrl_pkg.sv
hw/ctrl_regs.sv
hw/exec_monitor.sv
hw/spi_master.sv
hw/sys_ctrl_top.sv
tb/tb_sys_ctrl.sv

//--- tb/tb_sys_ctrl.sv
`timescale 1ns/100ps

module tb_sys_ctrl
  import sys_ctrl_pkg::*;
();

  localparam int clk_period   = 100;
  localparam int spi_clk_div  = 4;
  localparam int reset_cycles = 16;
  localparam int spi_cycles   = 16 * spi_clk_div;
  // Seven resets, about a hundred two-cycle bus accesses, one transfer, plus margin
  localparam int watchdog_cycles = 7 * reset_cycles + 2 * 100 + spi_cycles + 400;
  localparam word_t lfsr_taps = 32'h8020_0003;

  logic      clk;
  logic      reset_n;
  logic      cs;
  logic      we;
  reg_addr_t address;
  word_t     write_data;
  word_t     read_data;
  logic      ready;
  logic      system_mode;
  logic      system_reset;
  logic      cpu_valid;
  logic      cpu_instr;
  word_t     cpu_addr;
  logic      force_trap;
  logic      spi_ss;
  logic      spi_sck;
  logic      spi_mosi;
  logic      spi_miso;

  int        error_count;
  word_t     lfsr_state;

  // SPI slave model state
  byte_t     slave_tx;
  byte_t     slave_shift;
  byte_t     slave_rx;

  sys_ctrl_top #(
    .spi_clk_div (spi_clk_div)
  ) u_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (cs),
    .we           (we),
    .address      (address),
    .write_data   (write_data),
    .read_data    (read_data),
    .ready        (ready),
    .system_mode  (system_mode),
    .system_reset (system_reset),
    .cpu_valid    (cpu_valid),
    .cpu_instr    (cpu_instr),
    .cpu_addr     (cpu_addr),
    .force_trap   (force_trap),
    .spi_ss       (spi_ss),
    .spi_sck      (spi_sck),
    .spi_mosi     (spi_mosi),
    .spi_miso     (spi_miso)
  );

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------------------------------------
  // SPI slave, mode 0, MSB first
  // ------------------------------------------------------------
  assign spi_miso = slave_shift[7];

  always @(negedge spi_ss) slave_shift = slave_tx;
  always @(negedge spi_sck) slave_shift = {slave_shift[6:0], 1'b0};
  always @(posedge spi_sck) slave_rx = {slave_rx[6:0], spi_mosi};

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // Galois LFSR, one step per bit taken
  function automatic word_t rand_bits(input int count);
    word_t value;
    logic  lsb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ lfsr_taps;
      end
      value = {value[30:0], lsb};
    end
    return value;
  endfunction

  task automatic compare_word(input string name, input word_t actual, input word_t expected);
    assert (actual === expected) else begin
      $display("FAILED at %0t: %s expected 0x%h actual 0x%h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic require(input logic condition, input string what);
    assert (condition === 1'b1) else begin
      $display("ERROR at %0t: %s", $time, what);
      error_count++;
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input word_t data);
    @(negedge clk);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t addr, output word_t data);
    @(negedge clk);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    #10;
    require(ready, "bus ready did not follow chip select");
    data = read_data;
    @(negedge clk);
    cs = 1'b0;
  endtask

  task automatic read_and_compare(input reg_addr_t addr, input word_t expected,
                                  input string name);
    word_t value;
    bus_read(addr, value);
    compare_word(name, value, expected);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset_n = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    reset_n = 1'b1;
  endtask

  // One CPU access, trap flag sampled one cycle later
  task automatic access_and_expect(input logic instr, input word_t addr, input logic trap);
    @(negedge clk);
    cpu_valid = 1'b1;
    cpu_instr = instr;
    cpu_addr  = addr;
    @(negedge clk);
    cpu_valid = 1'b0;
    cpu_instr = 1'b0;
    compare_word("force_trap", force_trap, trap);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic identification_and_reset_state();
    compare_word("system_mode", system_mode, 0);
    compare_word("force_trap", force_trap, 0);
    compare_word("system_reset", system_reset, 0);
    compare_word("spi_ss", spi_ss, 1);
    compare_word("spi_sck", spi_sck, 0);
    read_and_compare(addr_name0, core_name0, "name0");
    read_and_compare(addr_name1, core_name1, "name1");
    read_and_compare(addr_version, core_version, "version");
    read_and_compare(8'h55, 32'h0, "unmapped read_data");
  endtask

  task automatic write_locking();
    word_t start_val;
    word_t size_val;
    word_t first_val;
    word_t last_val;
    start_val = rand_bits(32);
    size_val  = rand_bits(32);
    bus_write(addr_app_start, start_val);
    bus_write(addr_app_size, size_val);
    read_and_compare(addr_app_start, start_val, "app_start");
    read_and_compare(addr_app_size, size_val, "app_size");
    bus_write(addr_system_mode, 32'h1);
    compare_word("system_mode", system_mode, 1);
    read_and_compare(addr_system_mode, 32'h1, "system_mode readback");
    bus_write(addr_app_start, rand_bits(32));
    bus_write(addr_app_size, rand_bits(32));
    read_and_compare(addr_app_start, start_val, "locked app_start");
    read_and_compare(addr_app_size, size_val, "locked app_size");

    first_val = rand_bits(32);
    last_val  = rand_bits(32);
    bus_write(addr_mon_first, first_val);
    bus_write(addr_mon_last, last_val);
    read_and_compare(addr_mon_first, first_val, "mon_first");
    read_and_compare(addr_mon_last, last_val, "mon_last");
    bus_write(addr_mon_ctrl, 32'h1);
    bus_write(addr_mon_first, rand_bits(32));
    bus_write(addr_mon_last, rand_bits(32));
    read_and_compare(addr_mon_first, first_val, "locked mon_first");
    read_and_compare(addr_mon_last, last_val, "locked mon_last");
  endtask

  task automatic reset_pulse();
    compare_word("system_reset", system_reset, 0);
    bus_write(addr_system_reset, 32'h1);
    compare_word("system_reset", system_reset, 1);
    @(negedge clk);
    compare_word("system_reset", system_reset, 0);
    @(negedge clk);
    compare_word("system_reset", system_reset, 0);
  endtask

  task automatic security_monitor();
    apply_reset();
    access_and_expect(1'b0, 32'h4001_fffc, 1'b0);

    apply_reset();
    access_and_expect(1'b0, 32'h4002_0000, 1'b1);
    access_and_expect(1'b0, 32'h4000_0000, 1'b1);
    read_and_compare(addr_trap_status, 32'h1, "trap_status");

    apply_reset();
    access_and_expect(1'b1, 32'hd000_0400, 1'b1);

    apply_reset();
    access_and_expect(1'b0, 32'hd000_07ff, 1'b0);

    apply_reset();
    bus_write(addr_mon_first, 32'h2000_0100);
    bus_write(addr_mon_last, 32'h2000_01ff);
    bus_write(addr_mon_ctrl, 32'h1);
    access_and_expect(1'b1, 32'h2000_0200, 1'b0);
    access_and_expect(1'b0, 32'h2000_0180, 1'b0);
    access_and_expect(1'b1, 32'h2000_01ff, 1'b1);
    repeat (3) @(negedge clk);
    compare_word("force_trap", force_trap, 1);
    read_and_compare(addr_trap_status, 32'h1, "trap_status");
  endtask

  task automatic spi_transfer();
    byte_t tx_byte;
    word_t status;
    int    tries;
    tx_byte  = byte_t'(rand_bits(8));
    slave_tx = byte_t'(rand_bits(8));
    bus_write(addr_spi_en, 32'h1);
    compare_word("spi_ss", spi_ss, 0);
    bus_write(addr_spi_data, {24'h0, tx_byte});
    bus_write(addr_spi_xfer, 32'h1);
    read_and_compare(addr_spi_xfer, 32'h0, "spi_ready while busy");

    status = '0;
    tries  = 0;
    while (status[0] !== 1'b1 && tries < spi_cycles) begin
      bus_read(addr_spi_xfer, status);
      tries++;
    end
    require(status[0], "SPI transfer never reported ready");
    compare_word("slave captured mosi", slave_rx, tx_byte);
    read_and_compare(addr_spi_data, {24'h0, slave_tx}, "spi_rx_data");
    bus_write(addr_spi_en, 32'h0);
    compare_word("spi_ss", spi_ss, 1);
  endtask

  // ------------------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    cs          = 1'b0;
    we          = 1'b0;
    address     = '0;
    write_data  = '0;
    cpu_valid   = 1'b0;
    cpu_instr   = 1'b0;
    cpu_addr    = '0;
    slave_tx    = '0;
    slave_shift = '0;
    slave_rx    = '0;
    error_count = 0;
    lfsr_state  = 92988;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    identification_and_reset_state();
    write_locking();
    reset_pulse();
    security_monitor();
    apply_reset();
    spi_transfer();

    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired before the tests finished, %0d errors so far", error_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- hw/sys_ctrl_top.sv
`timescale 1ns/100ps

module sys_ctrl_top
  import sys_ctrl_pkg::*;
#(
  parameter int spi_clk_div = 4
) (
  input  logic      clk,
  input  logic      reset_n,

  input  logic      cs,
  input  logic      we,
  input  reg_addr_t address,
  input  word_t     write_data,
  output word_t     read_data,
  output logic      ready,

  output logic      system_mode,
  output logic      system_reset,

  input  logic      cpu_valid,
  input  logic      cpu_instr,
  input  word_t     cpu_addr,
  output logic      force_trap,

  output logic      spi_ss,
  output logic      spi_sck,
  output logic      spi_mosi,
  input  logic      spi_miso
);

  // ------------------------------------------------------------
  // Internal links
  // ------------------------------------------------------------
  logic  mon_en;
  word_t mon_first;
  word_t mon_last;

  logic  spi_enable;
  logic  spi_enable_vld;
  logic  spi_start;
  byte_t spi_tx_data;
  logic  spi_tx_vld;
  logic  spi_ready;
  byte_t spi_rx_data;

  ctrl_regs u_ctrl_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .cs             (cs),
    .we             (we),
    .address        (address),
    .write_data     (write_data),
    .read_data      (read_data),
    .ready          (ready),
    .system_mode    (system_mode),
    .system_reset   (system_reset),
    .force_trap     (force_trap),
    .mon_en         (mon_en),
    .mon_first      (mon_first),
    .mon_last       (mon_last),
    .spi_enable     (spi_enable),
    .spi_enable_vld (spi_enable_vld),
    .spi_start      (spi_start),
    .spi_tx_data    (spi_tx_data),
    .spi_tx_vld     (spi_tx_vld),
    .spi_ready      (spi_ready),
    .spi_rx_data    (spi_rx_data)
  );

  exec_monitor u_exec_monitor (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu_valid  (cpu_valid),
    .cpu_instr  (cpu_instr),
    .cpu_addr   (cpu_addr),
    .mon_en     (mon_en),
    .mon_first  (mon_first),
    .mon_last   (mon_last),
    .force_trap (force_trap)
  );

  spi_master #(
    .spi_clk_div (spi_clk_div)
  ) u_spi_master (
    .clk            (clk),
    .reset_n        (reset_n),
    .spi_enable     (spi_enable),
    .spi_enable_vld (spi_enable_vld),
    .spi_start      (spi_start),
    .spi_tx_data    (spi_tx_data),
    .spi_tx_vld     (spi_tx_vld),
    .spi_rx_data    (spi_rx_data),
    .spi_ready      (spi_ready),
    .spi_ss         (spi_ss),
    .spi_sck        (spi_sck),
    .spi_mosi       (spi_mosi),
    .spi_miso       (spi_miso)
  );

endmodule

//--- hw/spi_master.sv
`timescale 1ns/100ps

module spi_master
  import sys_ctrl_pkg::*;
#(
  parameter int spi_clk_div = 4
) (
  input  logic  clk,
  input  logic  reset_n,

  input  logic  spi_enable,
  input  logic  spi_enable_vld,
  input  logic  spi_start,
  input  byte_t spi_tx_data,
  input  logic  spi_tx_vld,
  output byte_t spi_rx_data,
  output logic  spi_ready,

  output logic  spi_ss,
  output logic  spi_sck,
  output logic  spi_mosi,
  input  logic  spi_miso
);

  localparam int div_w = $clog2(spi_clk_div);
  localparam logic [div_w-1:0] div_last = div_w'(spi_clk_div - 1);

  typedef enum logic [1:0] {
    idle,
    shift,
    done
  } spi_state_t;

  spi_state_t       state;
  logic [div_w-1:0] div_ctr;
  logic [2:0]       bit_ctr;
  logic             enable_reg;
  byte_t            tx_shift;
  byte_t            rx_shift;
  logic             half_tick;

  assign half_tick   = (div_ctr == div_last);
  assign spi_ss      = ~enable_reg;
  assign spi_mosi    = tx_shift[7];
  assign spi_rx_data = rx_shift;
  assign spi_ready   = (state == idle);

  // ------------------------------------------------------------
  // Chip select level
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      enable_reg <= 1'b0;
    end else if (spi_enable_vld) begin
      enable_reg <= spi_enable;
    end
  end

  // ------------------------------------------------------------
  // Transfer FSM
  // ------------------------------------------------------------
  // Shift covers 15 SCK half periods, done holds the last high phase
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state   <= idle;
      spi_sck <= 1'b0;
      div_ctr <= '0;
      bit_ctr <= '0;
    end else begin
      case (state)
        idle: begin
          div_ctr <= '0;
          bit_ctr <= '0;
          if (spi_start) begin
            state <= shift;
          end
        end

        shift: begin
          div_ctr <= half_tick ? '0 : div_ctr + 1'b1;
          if (half_tick) begin
            spi_sck <= ~spi_sck;
            if (!spi_sck && bit_ctr == 3'd7) begin
              state <= done;
            end
            if (spi_sck) begin
              bit_ctr <= bit_ctr + 1'b1;
            end
          end
        end

        done: begin
          div_ctr <= half_tick ? '0 : div_ctr + 1'b1;
          if (half_tick) begin
            spi_sck <= 1'b0;
            state   <= idle;
          end
        end

        default: state <= idle;
      endcase
    end
  end

  // Data path, MSB first
  always_ff @(posedge clk) begin
    if (state == idle && spi_tx_vld) begin
      tx_shift <= spi_tx_data;
    end else if (state == shift && half_tick && spi_sck) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end

    // Sample on the rising SCK edge
    if (state == shift && half_tick && !spi_sck) begin
      rx_shift <= {rx_shift[6:0], spi_miso};
    end
  end

  // SCK idles low between transfers
  assert property (@(posedge clk) disable iff (!reset_n)
    spi_ready |-> !spi_sck);

endmodule

//--- hw/exec_monitor.sv
`timescale 1ns/100ps

module exec_monitor
  import sys_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,

  input  logic  cpu_valid,
  input  logic  cpu_instr,
  input  word_t cpu_addr,

  input  logic  mon_en,
  input  word_t mon_first,
  input  word_t mon_last,

  output logic  force_trap
);

  logic ram_overrun;
  logic fw_ram_fetch;
  logic window_fetch;
  logic trap_set;

  // ------------------------------------------------------------
  // Access rules
  // ------------------------------------------------------------

  // RAM space is selected by the top two address bits
  assign ram_overrun = (cpu_addr[31:30] == 2'b01) && (cpu_addr >= ram_size_limit);

  // Firmware RAM is data only
  assign fw_ram_fetch = cpu_instr &&
                        (cpu_addr >= fw_ram_first) && (cpu_addr <= fw_ram_last);

  // Software-defined data-only window, bounds inclusive
  assign window_fetch = mon_en && cpu_instr &&
                        (cpu_addr >= mon_first) && (cpu_addr <= mon_last);

  assign trap_set = cpu_valid && (ram_overrun || fw_ram_fetch || window_fetch);

  // ------------------------------------------------------------
  // Sticky trap
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap <= 1'b0;
    end else if (trap_set) begin
      force_trap <= 1'b1;
    end
  end

  // Only a reset may clear the trap
  assert property (@(posedge clk)
    $fell(force_trap) |-> !$past(reset_n));

endmodule

//--- hw/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs
  import sys_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,

  input  logic      cs,
  input  logic      we,
  input  reg_addr_t address,
  input  word_t     write_data,
  output word_t     read_data,
  output logic      ready,

  output logic      system_mode,
  output logic      system_reset,

  input  logic      force_trap,
  output logic      mon_en,
  output word_t     mon_first,
  output word_t     mon_last,

  output logic      spi_enable,
  output logic      spi_enable_vld,
  output logic      spi_start,
  output byte_t     spi_tx_data,
  output logic      spi_tx_vld,
  input  logic      spi_ready,
  input  byte_t     spi_rx_data
);

  // ------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------
  logic  bus_write;
  logic  bus_read;

  logic  system_mode_we;
  logic  app_start_we;
  logic  app_size_we;
  logic  mon_en_we;
  logic  mon_first_we;
  logic  mon_last_we;
  logic  system_reset_new;

  word_t app_start_reg;
  word_t app_size_reg;

  assign bus_write = cs & we;
  assign bus_read  = cs & ~we;
  assign ready     = cs;

  // Payload for the SPI strobes comes straight off the write bus
  assign spi_enable  = write_data[0];
  assign spi_tx_data = write_data[7:0];

  always_comb begin
    system_mode_we   = 1'b0;
    app_start_we     = 1'b0;
    app_size_we      = 1'b0;
    mon_en_we        = 1'b0;
    mon_first_we     = 1'b0;
    mon_last_we      = 1'b0;
    system_reset_new = 1'b0;
    spi_enable_vld   = 1'b0;
    spi_start        = 1'b0;
    spi_tx_vld       = 1'b0;

    if (bus_write) begin
      case (address)
        addr_system_mode:  system_mode_we = 1'b1;
        // App window frozen once firmware mode is left
        addr_app_start:    app_start_we = ~system_mode;
        addr_app_size:     app_size_we  = ~system_mode;
        addr_mon_ctrl:     mon_en_we = 1'b1;
        // Bounds frozen once the monitor is armed
        addr_mon_first:    mon_first_we = ~mon_en;
        addr_mon_last:     mon_last_we  = ~mon_en;
        addr_system_reset: system_reset_new = 1'b1;
        addr_spi_en:       spi_enable_vld = 1'b1;
        addr_spi_xfer:     spi_start = 1'b1;
        addr_spi_data:     spi_tx_vld = 1'b1;
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Register update
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      system_mode   <= 1'b0;
      system_reset  <= 1'b0;
      app_start_reg <= '0;
      app_size_reg  <= '0;
      mon_en        <= 1'b0;
      mon_first     <= '0;
      mon_last      <= '0;
    end else begin
      system_reset <= system_reset_new;

      if (system_mode_we) begin
        system_mode <= 1'b1;
      end
      if (app_start_we) begin
        app_start_reg <= write_data;
      end
      if (app_size_we) begin
        app_size_reg <= write_data;
      end
      if (mon_en_we) begin
        mon_en <= 1'b1;
      end
      if (mon_first_we) begin
        mon_first <= write_data;
      end
      if (mon_last_we) begin
        mon_last <= write_data;
      end
    end
  end

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------
  always_comb begin
    read_data = '0;
    if (bus_read) begin
      case (address)
        addr_name0:       read_data = core_name0;
        addr_name1:       read_data = core_name1;
        addr_version:     read_data = core_version;
        addr_system_mode: read_data = {31'h0, system_mode};
        addr_app_start:   read_data = app_start_reg;
        addr_app_size:    read_data = app_size_reg;
        addr_mon_ctrl:    read_data = {31'h0, mon_en};
        addr_mon_first:   read_data = mon_first;
        addr_mon_last:    read_data = mon_last;
        addr_trap_status: read_data = {31'h0, force_trap};
        addr_spi_xfer:    read_data = {31'h0, spi_ready};
        addr_spi_data:    read_data = {24'h0, spi_rx_data};
        default:          read_data = '0;
      endcase
    end
  end

  // Reset request never lasts two cycles
  assert property (@(posedge clk) disable iff (!reset_n)
    system_reset |=> !system_reset);

endmodule

//--- hw/sys_ctrl_pkg.sv
package sys_ctrl_pkg;

  // ------------------------------------------------------------
  // Word types
  // ------------------------------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [7:0]  byte_t;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  localparam reg_addr_t addr_name0       = 8'h00;
  localparam reg_addr_t addr_name1       = 8'h01;
  localparam reg_addr_t addr_version     = 8'h02;
  localparam reg_addr_t addr_system_mode = 8'h08;
  localparam reg_addr_t addr_app_start   = 8'h0c;
  localparam reg_addr_t addr_app_size    = 8'h0d;
  localparam reg_addr_t addr_mon_ctrl    = 8'h60;
  localparam reg_addr_t addr_mon_first   = 8'h61;
  localparam reg_addr_t addr_mon_last    = 8'h62;
  localparam reg_addr_t addr_trap_status = 8'h63;
  localparam reg_addr_t addr_system_reset = 8'h70;
  localparam reg_addr_t addr_spi_en      = 8'h80;
  localparam reg_addr_t addr_spi_xfer    = 8'h81;
  localparam reg_addr_t addr_spi_data    = 8'h82;

  // ASCII "ctl " and "sysc"
  localparam word_t core_name0   = 32'h63746c20;
  localparam word_t core_name1   = 32'h73797363;
  localparam word_t core_version = 32'h00000001;

  // Memory map limits
  localparam word_t fw_ram_first   = 32'hd000_0000;
  localparam word_t fw_ram_last    = 32'hd000_07ff;
  // First address past the 128 KiB RAM at 0x4000_0000
  localparam word_t ram_size_limit = 32'h4002_0000;

endpackage
